// ==== source/tg_defs.svh ====
// *********************************************************************
// Traffic generator constants: lane count, sample total, burst and
// gap limits, stall settings and test mode encodings
// *********************************************************************

`ifndef TG_DEFS_SVH
`define TG_DEFS_SVH

// Link width and test length
`define TG_LANES              4
`define TG_TOTAL_SAMPLES      300

// Burst length runs from 2 up to this value
`define TG_MAX_BURST          100

// Idle gap between bursts runs from 1 up to this value
`define TG_MAX_GAP            16

// Stall start threshold against 7 PRBS bits, and longest stall
`define TG_STALL_PCT          1
`define TG_STALL_MAX          3

// Test mode encodings
`define TG_MODE_CONTINUOUS    0
`define TG_MODE_BURST         1

`endif

// ==== source/tg_pkg.sv ====
// *********************************************************************
// Traffic generator types: FSM state enums and the lane word union
// *********************************************************************

`default_nettype none

package tg_pkg;

   // Burst sequencer states
   typedef enum logic [2:0] {
      TG_INIT,
      TG_IDLE,
      TG_ACTIVE_BURST,
      TG_ACTIVE_CONT,
      TG_COMPLETE
   } tg_state_e;

   // Stall scheduler states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACTIVE,
      ST_STALLING
   } stall_state_e;

   // Field view of one lane word
   typedef struct packed {
      logic [4:0]  lane_id;
      logic [26:0] burst_num;
      logic [31:0] sample_num;
   } lane_fields_t;

   // Lane word, seen either as a raw bus word or as its fields
   typedef union packed {
      logic [63:0]  raw;
      lane_fields_t fields;
   } lane_word_u;

endpackage

`default_nettype wire

// ==== source/tg_ctrl_if.sv ====
// *********************************************************************
// Control strobes from the burst sequencer to the stall scheduler
// and the lane payload registers
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

interface tg_ctrl_if;

   logic start_of_burst;
   logic end_of_burst;
   logic valid;
   // Pulses in the cycle before start_of_burst rises
   logic next_start;
   // High from the first beat until the cycle after the last
   logic in_burst;

   modport sequencer (output start_of_burst, end_of_burst, valid, next_start, in_burst);
   modport stall (input start_of_burst, end_of_burst, in_burst);
   modport payload (input next_start, valid);

endinterface

`default_nettype wire

// ==== source/prbs_source.sv ====
// *********************************************************************
// PRBS-23 source, 32 new bits per clock
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

module prbs_source (
   input  wire         user_clock,
   input  wire         user_clock_reset,
   output logic [31:0] prbs
);

   localparam logic [22:0] lfsr_seed = 23'd97;

   logic [22:0] lfsr_q;
   logic [22:0] lfsr_n;

   // Polynomial x^23 + x^18 + 1, unrolled 32 shifts deep
   always_comb begin
      lfsr_n = lfsr_q;
      for (int i = 0; i < 32; i++) begin
         prbs[i] = lfsr_n[22] ^ lfsr_n[17];
         lfsr_n  = {lfsr_n[21:0], prbs[i]};
      end
   end

   always_ff @(posedge user_clock or posedge user_clock_reset) begin
      if (user_clock_reset) begin
         lfsr_q <= lfsr_seed;
      end else begin
         lfsr_q <= lfsr_n;
      end
   end

endmodule

`default_nettype wire

// ==== source/stall_scheduler.sv ====
// *********************************************************************
// Stall scheduler: picks random points inside a burst where the
// stream freezes, and how many cycles each freeze lasts
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module stall_scheduler (
   input  wire         user_clock,
   input  wire         user_clock_reset,
   input  wire         enable_stalls,
   input  wire  [31:0] prbs,
   tg_ctrl_if.stall    ctrl,
   output logic        stall
);

   tg_pkg::stall_state_e state_q;

   logic       stalls_meta;
   logic       stalls_sync;
   logic       stall_hit;
   logic [2:0] stall_len;
   logic [2:0] stall_left;

   // Two-flop synchronizer for the stall enable
   always_ff @(posedge user_clock or posedge user_clock_reset) begin
      if (user_clock_reset) begin
         stalls_meta <= 1'b0;
         stalls_sync <= 1'b0;
      end else begin
         stalls_meta <= enable_stalls;
         stalls_sync <= stalls_meta;
      end
   end

   assign stall_hit = stalls_sync && (prbs[6:0] <= 7'(`TG_STALL_PCT));
   // Out of range draws fall back to a single cycle
   assign stall_len = (prbs[9:7] < 3'(`TG_STALL_MAX)) ? prbs[9:7] + 3'd1 : 3'd1;

   always_ff @(posedge user_clock or posedge user_clock_reset) begin
      if (user_clock_reset) begin
         state_q    <= tg_pkg::ST_IDLE;
         stall      <= 1'b0;
         stall_left <= 3'd0;
      end else begin
         case (state_q)
            tg_pkg::ST_IDLE: begin
               // The first beat itself is never a stall candidate
               if (ctrl.start_of_burst) begin
                  state_q <= tg_pkg::ST_ACTIVE;
               end
            end
            tg_pkg::ST_ACTIVE: begin
               if (!ctrl.in_burst) begin
                  state_q <= tg_pkg::ST_IDLE;
               end else if (stall_hit && !ctrl.end_of_burst) begin
                  state_q    <= tg_pkg::ST_STALLING;
                  stall      <= 1'b1;
                  stall_left <= stall_len;
               end
            end
            tg_pkg::ST_STALLING: begin
               if (stall_left <= 3'd1) begin
                  stall   <= 1'b0;
                  state_q <= ctrl.in_burst ? tg_pkg::ST_ACTIVE : tg_pkg::ST_IDLE;
               end else begin
                  stall_left <= stall_left - 3'd1;
               end
            end
            default: begin
               state_q <= tg_pkg::ST_IDLE;
               stall   <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/burst_sequencer.sv ====
// *********************************************************************
// Burst sequencer: control FSM for framing, valid, sync codes and
// the beat and word status counters
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module burst_sequencer (
   input  wire          user_clock,
   input  wire          user_clock_reset,
   input  wire          enable,
   input  wire          test_mode,
   input  wire          link_up,
   input  wire          stall,
   input  wire  [31:0]  prbs,
   tg_ctrl_if.sequencer ctrl,
   output logic [3:0]   sync,
   output logic [15:0]  burst_count,
   output logic [63:0]  words_transferred
);

   localparam logic [63:0] total_words = 64'(`TG_TOTAL_SAMPLES);
   localparam logic [15:0] burst_span  = 16'(`TG_MAX_BURST - 1);
   localparam logic [4:0]  gap_span    = 5'(`TG_MAX_GAP);

   tg_pkg::tg_state_e state_q;
   tg_pkg::tg_state_e state_n;

   logic        enable_meta;
   logic        enable_sync;
   logic        mode_meta;
   logic        mode_sync;
   logic        burst_mode;
   logic        start;
   logic        beat;
   logic        sob_n;
   logic        eob_n;
   logic        in_burst_n;
   logic [3:0]  sync_n;
   logic [4:0]  gap_q;
   logic [4:0]  gap_n;
   logic [4:0]  gap_draw;
   logic [15:0] burst_len_q;
   logic [15:0] burst_len_n;
   logic [15:0] burst_count_n;
   logic [15:0] len_draw;
   logic [63:0] words_n;

   // Two-flop synchronizers for enable and test mode
   always_ff @(posedge user_clock or posedge user_clock_reset) begin
      if (user_clock_reset) begin
         enable_meta <= 1'b0;
         enable_sync <= 1'b0;
         mode_meta   <= 1'(`TG_MODE_BURST);
         mode_sync   <= 1'(`TG_MODE_BURST);
      end else begin
         enable_meta <= enable;
         enable_sync <= enable_meta;
         mode_meta   <= test_mode;
         mode_sync   <= mode_meta;
      end
   end

   assign burst_mode = (mode_sync == 1'(`TG_MODE_BURST));

   // Random burst length 2..MAX_BURST and gap 1..MAX_GAP, folded into range
   always_comb begin
      len_draw = {9'd0, prbs[22:16]};
      if (len_draw >= burst_span)
         len_draw = len_draw - burst_span;
      len_draw = len_draw + 16'd2;
      gap_draw = prbs[28:24];
      if (gap_draw >= gap_span)
         gap_draw = gap_draw - gap_span;
      gap_draw = gap_draw + 5'd1;
   end

   assign start = (state_q == tg_pkg::TG_IDLE) && (words_transferred < total_words) &&
                  link_up && enable_sync && (gap_q == 5'd0);
   assign ctrl.next_start = start && !stall;

   always_comb begin
      state_n       = state_q;
      gap_n         = gap_q;
      burst_len_n   = burst_len_q;
      burst_count_n = burst_count;
      beat          = 1'b0;
      case (state_q)
         tg_pkg::TG_INIT: state_n = tg_pkg::TG_IDLE;
         tg_pkg::TG_IDLE: begin
            if (gap_q != 5'd0)
               gap_n = gap_q - 5'd1;
            if (start) begin
               state_n       = burst_mode ? tg_pkg::TG_ACTIVE_BURST : tg_pkg::TG_ACTIVE_CONT;
               burst_len_n   = burst_mode ? len_draw : 16'd0;
               burst_count_n = 16'd1;
               beat          = 1'b1;
            end
         end
         tg_pkg::TG_ACTIVE_BURST, tg_pkg::TG_ACTIVE_CONT: begin
            burst_count_n = burst_count + 16'd1;
            beat          = 1'b1;
         end
         tg_pkg::TG_COMPLETE: begin
            state_n       = tg_pkg::TG_IDLE;
            burst_count_n = 16'd0;
            gap_n         = burst_mode ? gap_draw : 5'd0;
         end
         default: state_n = tg_pkg::TG_IDLE;
      endcase

      // Every beat takes a fresh sync code and may close the burst
      words_n = beat ? words_transferred + 64'd1 : words_transferred;
      sync_n  = beat ? prbs[3:0] : sync;
      sob_n   = beat && (state_q == tg_pkg::TG_IDLE);
      eob_n   = beat && ((words_n == total_words) || !enable_sync ||
                ((state_n == tg_pkg::TG_ACTIVE_BURST) && (burst_count_n >= burst_len_n)));
      if (eob_n)
         state_n = tg_pkg::TG_COMPLETE;
      in_burst_n = state_n inside {tg_pkg::TG_ACTIVE_BURST, tg_pkg::TG_ACTIVE_CONT,
                                   tg_pkg::TG_COMPLETE};
   end

   always_ff @(posedge user_clock or posedge user_clock_reset) begin
      if (user_clock_reset) begin
         state_q             <= tg_pkg::TG_INIT;
         gap_q               <= 5'd0;
         burst_len_q         <= 16'd0;
         burst_count         <= 16'd0;
         words_transferred   <= 64'd0;
         sync                <= 4'd0;
         ctrl.valid          <= 1'b0;
         ctrl.start_of_burst <= 1'b0;
         ctrl.end_of_burst   <= 1'b0;
         ctrl.in_burst       <= 1'b0;
      end else if (stall) begin
         // Freeze everything, only the beat strobes drop
         ctrl.valid          <= 1'b0;
         ctrl.start_of_burst <= 1'b0;
         ctrl.end_of_burst   <= 1'b0;
      end else begin
         state_q             <= state_n;
         gap_q               <= gap_n;
         burst_len_q         <= burst_len_n;
         burst_count         <= burst_count_n;
         words_transferred   <= words_n;
         sync                <= sync_n;
         ctrl.valid          <= beat;
         ctrl.start_of_burst <= sob_n;
         ctrl.end_of_burst   <= eob_n;
         ctrl.in_burst       <= in_burst_n;
      end
   end

endmodule

`default_nettype wire

// ==== source/lane_payload.sv ====
// *********************************************************************
// Per-lane payload registers holding lane, burst and sample numbers
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module lane_payload (
   input  wire          user_clock,
   input  wire          user_clock_reset,
   tg_ctrl_if.payload   ctrl,
   output tg_pkg::lane_word_u data [`TG_LANES]
);

   for (genvar i = 0; i < `TG_LANES; i++) begin : g_lane
      tg_pkg::lane_word_u word_q;

      always_ff @(posedge user_clock or posedge user_clock_reset) begin
         if (user_clock_reset) begin
            word_q.fields.lane_id    <= 5'(i);
            word_q.fields.burst_num  <= 27'd0;
            word_q.fields.sample_num <= 32'd1;
         end else if (ctrl.next_start) begin
            word_q.fields.burst_num <= word_q.fields.burst_num + 27'd1;
         end else if (ctrl.valid) begin
            // Advance once the beat has gone out
            word_q.fields.sample_num <= word_q.fields.sample_num + 32'd1;
         end
      end

      assign data[i] = word_q;
   end

endmodule

`default_nettype wire

// ==== source/traffic_gen.sv ====
// *********************************************************************
// Traffic generator top: PRBS source, stall scheduler, burst
// sequencer and lane payload, with flat output ports
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module traffic_gen (
   input  wire                      user_clock,
   input  wire                      user_clock_reset,
   input  wire                      link_up,
   input  wire                      tg_enable,
   input  wire                      tg_test_mode,
   input  wire                      tg_enable_stalls,
   output wire [(`TG_LANES*64)-1:0] data,
   output wire [3:0]                sync,
   output wire                      valid,
   output wire                      start_of_burst,
   output wire                      end_of_burst,
   output wire [15:0]               tg_burst_count,
   output wire [63:0]               tg_words_transferred
);

   tg_ctrl_if ctrl_bus ();

   logic [31:0]        prbs;
   logic               stall;
   tg_pkg::lane_word_u lane_data [`TG_LANES];

   prbs_source prbs_source_inst (
      .user_clock       (user_clock),
      .user_clock_reset (user_clock_reset),
      .prbs             (prbs)
   );

   stall_scheduler stall_scheduler_inst (
      .user_clock       (user_clock),
      .user_clock_reset (user_clock_reset),
      .enable_stalls    (tg_enable_stalls),
      .prbs             (prbs),
      .ctrl             (ctrl_bus.stall),
      .stall            (stall)
   );

   burst_sequencer burst_sequencer_inst (
      .user_clock        (user_clock),
      .user_clock_reset  (user_clock_reset),
      .enable            (tg_enable),
      .test_mode         (tg_test_mode),
      .link_up           (link_up),
      .stall             (stall),
      .prbs              (prbs),
      .ctrl              (ctrl_bus.sequencer),
      .sync              (sync),
      .burst_count       (tg_burst_count),
      .words_transferred (tg_words_transferred)
   );

   lane_payload lane_payload_inst (
      .user_clock       (user_clock),
      .user_clock_reset (user_clock_reset),
      .ctrl             (ctrl_bus.payload),
      .data             (lane_data)
   );

   // Lane i sits at bits [64*i +: 64]
   for (genvar i = 0; i < `TG_LANES; i++) begin : g_flat
      assign data[64*i +: 64] = lane_data[i].raw;
   end

   assign valid          = ctrl_bus.valid;
   assign start_of_burst = ctrl_bus.start_of_burst;
   assign end_of_burst   = ctrl_bus.end_of_burst;

endmodule

`default_nettype wire

// ==== dv/traffic_gen_tb.sv ====
// *********************************************************************
// Testbench for the traffic generator: clock, reset, LFSR stimulus,
// beat-level reference model and typed compare tasks
// *********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tg_defs.svh"

module traffic_gen_tb;

   localparam int total_samples = `TG_TOTAL_SAMPLES;
   localparam int run_timeout   = 20000;
   localparam int settle_cycles = 40;

   logic                      user_clock;
   logic                      user_clock_reset;
   logic                      link_up;
   logic                      tg_enable;
   logic                      tg_test_mode;
   logic                      tg_enable_stalls;
   wire [(`TG_LANES*64)-1:0]  data;
   wire [3:0]                 sync;
   wire                       valid;
   wire                       start_of_burst;
   wire                       end_of_burst;
   wire [15:0]                tg_burst_count;
   wire [63:0]                tg_words_transferred;

   logic [15:0] lfsr_state;

   // Reference model state
   int                        beats;
   int                        starts;
   int                        burst_beats;
   int                        gap_len;
   logic                      in_burst;
   logic                      prev_valid;
   logic                      burst_mode;
   logic                      stalls_on;
   logic [3:0]                last_sync;

   traffic_gen traffic_gen_inst (
      .user_clock           (user_clock),
      .user_clock_reset     (user_clock_reset),
      .link_up              (link_up),
      .tg_enable            (tg_enable),
      .tg_test_mode         (tg_test_mode),
      .tg_enable_stalls     (tg_enable_stalls),
      .data                 (data),
      .sync                 (sync),
      .valid                (valid),
      .start_of_burst       (start_of_burst),
      .end_of_burst         (end_of_burst),
      .tg_burst_count       (tg_burst_count),
      .tg_words_transferred (tg_words_transferred)
   );

   initial begin
      user_clock = 1'b0;
      forever #10 user_clock = ~user_clock;
   end

   // *******************************************************************
   // Random source and error reporting
   // *******************************************************************

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [7:0] value);
      value = 8'd0;
      for (int i = 0; i < n; i++) begin
         value      = {value[6:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_lane(input string name, input tg_pkg::lane_word_u got,
                             input tg_pkg::lane_word_u exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got.raw, exp.raw));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_code(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   // *******************************************************************
   // Reference model, sampled at the falling edge
   // *******************************************************************

   task automatic reset_model();
      beats       = 0;
      starts      = 0;
      burst_beats = 0;
      gap_len     = 0;
      in_burst    = 1'b0;
      prev_valid  = 1'b0;
      last_sync   = 4'd0;
   endtask

   task automatic observe_outputs();
      tg_pkg::lane_word_u got;
      tg_pkg::lane_word_u exp;
      if ((start_of_burst || end_of_burst) && !valid)
         abort_run("A framing strobe appeared without valid");
      if (start_of_burst) begin
         if (in_burst)
            abort_run("A burst started before the previous one ended");
         if (prev_valid)
            abort_run("No idle cycle separated two bursts");
         in_burst    = 1'b1;
         starts++;
         burst_beats = 0;
      end
      if (valid) begin
         if (!in_burst)
            abort_run("valid was high outside a burst");
         if (beats >= total_samples)
            abort_run("More valid beats than the sample total");
         for (int i = 0; i < `TG_LANES; i++) begin
            got.raw               = data[64*i +: 64];
            exp.fields.lane_id    = 5'(i);
            exp.fields.burst_num  = 27'(starts);
            exp.fields.sample_num = 32'(beats + 1);
            check_lane($sformatf("data lane %0d", i), got, exp);
         end
         beats++;
         burst_beats++;
         check_count("tg_words_transferred", tg_words_transferred, 64'(beats));
         check_count("tg_burst_count", 64'(tg_burst_count), 64'(burst_beats));
         last_sync = sync;
         gap_len   = 0;
      end else if (in_burst) begin
         if (!stalls_on)
            abort_run("valid dropped inside a burst with stalls disabled");
         gap_len++;
         if (gap_len > `TG_STALL_MAX)
            abort_run("A stall inside a burst lasted longer than the stall limit");
         check_code("sync", sync, last_sync);
         // Payload already shows the sample number of the next beat
         for (int i = 0; i < `TG_LANES; i++) begin
            got.raw               = data[64*i +: 64];
            exp.fields.lane_id    = 5'(i);
            exp.fields.burst_num  = 27'(starts);
            exp.fields.sample_num = 32'(beats + 1);
            check_lane($sformatf("data lane %0d during stall", i), got, exp);
         end
      end
      if (end_of_burst) begin
         // Only the final burst may be cut short by the sample total
         if (burst_mode && ((burst_beats > `TG_MAX_BURST) ||
             ((burst_beats < 2) && (beats != total_samples))))
            abort_run("Burst length outside the allowed range");
         if (!burst_mode && (burst_beats != total_samples))
            abort_run("Continuous burst does not cover all samples");
         in_burst = 1'b0;
      end
      prev_valid = valid;
   endtask

   task automatic tick();
      @(negedge user_clock);
      observe_outputs();
      @(posedge user_clock);
   endtask

   // *******************************************************************
   // Reset and run sequences
   // *******************************************************************

   task automatic apply_reset(input logic mode, input logic stalls);
      @(posedge user_clock);
      user_clock_reset <= 1'b1;
      tg_enable        <= 1'b0;
      link_up          <= 1'b0;
      tg_test_mode     <= mode;
      tg_enable_stalls <= stalls;
      repeat (2) @(posedge user_clock);
      @(negedge user_clock);
      check_bit("valid", valid, 1'b0);
      check_bit("start_of_burst", start_of_burst, 1'b0);
      check_bit("end_of_burst", end_of_burst, 1'b0);
      check_count("tg_words_transferred", tg_words_transferred, 64'd0);
      check_count("tg_burst_count", 64'(tg_burst_count), 64'd0);
      reset_model();
      @(posedge user_clock);
      user_clock_reset <= 1'b0;
      tg_enable        <= 1'b1;
   endtask

   task automatic run_test(input logic mode, input logic stalls);
      logic [7:0] count;
      logic [7:0] len;
      int         cycles;
      int         settle;
      burst_mode = (mode == 1'(`TG_MODE_BURST));
      stalls_on  = stalls;
      apply_reset(mode, stalls);
      // Short link dropouts before the link settles high
      take_bits(2, count);
      for (int d = 0; d <= int'(count); d++) begin
         take_bits(2, len);
         link_up <= 1'b1;
         repeat (int'(len) + 1) tick();
         take_bits(2, len);
         link_up <= 1'b0;
         repeat (int'(len) + 1) tick();
      end
      link_up <= 1'b1;
      cycles = 0;
      settle = 0;
      while (settle < settle_cycles) begin
         tick();
         cycles++;
         if ((beats == total_samples) && !in_burst)
            settle++;
         if (cycles > run_timeout)
            abort_run("Timed out waiting for the run to finish");
      end
      check_count("tg_words_transferred", tg_words_transferred, 64'(total_samples));
   endtask

   initial begin
      logic [7:0] pick;
      logic [1:0] combo;
      user_clock_reset = 1'b1;
      link_up          = 1'b0;
      tg_enable        = 1'b0;
      tg_test_mode     = 1'b0;
      tg_enable_stalls = 1'b0;
      lfsr_state       = 16'd22;
      burst_mode       = 1'b1;
      stalls_on        = 1'b0;
      reset_model();
      // Every mode and stall combination once, in a random order
      take_bits(2, pick);
      for (int r = 0; r < 4; r++) begin
         combo = 2'(int'(pick) + r);
         run_test(combo[0], combo[1]);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/tg_pkg.sv
source/tg_ctrl_if.sv
source/prbs_source.sv
source/stall_scheduler.sv
source/burst_sequencer.sv
source/lane_payload.sv
source/traffic_gen.sv
dv/traffic_gen_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --timescale 1ns/1ps
TOP      = traffic_gen_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
